// ==== Makefile ====
# Verilator build and run for the tile map display layer

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/tile_layer_sim
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -Wno-fatal \
		--top-module tile_layer_tb --Mdir $(OBJ_DIR) -o tile_layer_sim \
		-f verilog.f

run: compile
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/host_write_port.sv ====
// host write port for the tile layer
// splits host writes between map and glyph memory, parks each one in
// a pending register and commits it on the first cycle the renderer
// leaves that memory alone, renderer reads always win the address

`timescale 1ns/1ps

module host_write_port import tile_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // host side
    input  host_wr_t            host_wr,
    input  logic                host_we,
    // renderer read requests
    input  logic                map_rd,
    input  logic [MAP_AW-1:0]   map_rd_addr,
    input  logic                glyph_rd,
    input  logic [GLYPH_AW-1:0] glyph_rd_addr,
    // map memory port
    output logic [MAP_AW-1:0]   map_addr,
    output logic                map_we,
    output map_entry_t          map_data,
    // glyph memory port
    output logic [GLYPH_AW-1:0] glyph_addr,
    output logic                glyph_we,
    output glyph_row_t          glyph_data
);

    // host address decode
    logic sel_glyph;
    logic map_hit;
    logic glyph_hit;

    // one pending write per memory
    logic                map_pend_vld;
    logic [MAP_AW-1:0]   map_pend_addr;
    map_entry_t          map_pend_data;
    logic                glyph_pend_vld;
    logic [GLYPH_AW-1:0] glyph_pend_addr;
    glyph_row_t          glyph_pend_data;

    assign sel_glyph = host_wr.addr[HOST_AW-1];
    assign map_hit   = host_we && !sel_glyph;
    assign glyph_hit = host_we && sel_glyph;

    // valid flags
    // a new strobe wins over a commit on the same cycle, the commit
    // still writes the old word since the payload updates on the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            map_pend_vld   <= 1'b0;
            glyph_pend_vld <= 1'b0;
        end else begin
            if (map_hit) begin
                map_pend_vld <= 1'b1;
            end else if (map_we) begin
                map_pend_vld <= 1'b0;
            end
            if (glyph_hit) begin
                glyph_pend_vld <= 1'b1;
            end else if (glyph_we) begin
                glyph_pend_vld <= 1'b0;
            end
        end
    end

    // pending address and data
    always_ff @(posedge clk) begin
        if (map_hit) begin
            map_pend_addr <= host_wr.addr[MAP_AW-1:0];
            map_pend_data <= map_entry_t'(host_wr.data);
        end
        if (glyph_hit) begin
            glyph_pend_addr <= host_wr.addr[GLYPH_AW-1:0];
            glyph_pend_data <= glyph_row_t'(host_wr.data);
        end
    end

    // address muxes, read strobe first
    assign map_we     = map_pend_vld && !map_rd;
    assign map_addr   = map_rd ? map_rd_addr : map_pend_addr;
    assign map_data   = map_pend_data;

    assign glyph_we   = glyph_pend_vld && !glyph_rd;
    assign glyph_addr = glyph_rd ? glyph_rd_addr : glyph_pend_addr;
    assign glyph_data = glyph_pend_data;

endmodule

// ==== design/tile_layer_top.sv ====
// tile map display layer, top level
// raster timing drives the renderer, which reads map and glyph
// memories through the host write port, host writes slip into
// the free memory cycles

`timescale 1ns/1ps

module tile_layer_top import tile_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  host_wr_t host_wr,
    input  logic     host_we,
    output vid_out_t video
);

    raster_t             raster;

    // renderer read requests
    logic                map_rd;
    logic [MAP_AW-1:0]   map_rd_addr;
    logic                glyph_rd;
    logic [GLYPH_AW-1:0] glyph_rd_addr;

    // memory ports
    logic [MAP_AW-1:0]   map_addr;
    logic                map_we;
    map_entry_t          map_data;
    map_entry_t          map_q;
    logic [GLYPH_AW-1:0] glyph_addr;
    logic                glyph_we;
    glyph_row_t          glyph_data;
    glyph_row_t          glyph_q;

    vid_timing i_timing (
        .clk    (clk),
        .rst    (rst),
        .raster (raster)
    );

    host_write_port i_wr_port (
        .clk           (clk),
        .rst           (rst),
        .host_wr       (host_wr),
        .host_we       (host_we),
        .map_rd        (map_rd),
        .map_rd_addr   (map_rd_addr),
        .glyph_rd      (glyph_rd),
        .glyph_rd_addr (glyph_rd_addr),
        .map_addr      (map_addr),
        .map_we        (map_we),
        .map_data      (map_data),
        .glyph_addr    (glyph_addr),
        .glyph_we      (glyph_we),
        .glyph_data    (glyph_data)
    );

    // 32 tile entries
    tile_ram #(.payload_t(map_entry_t), .aw(MAP_AW)) i_map_ram (
        .clk  (clk),
        .addr (map_addr),
        .we   (map_we),
        .data (map_data),
        .q    (map_q)
    );

    // 16 codes of 8 rows
    tile_ram #(.payload_t(glyph_row_t), .aw(GLYPH_AW)) i_glyph_ram (
        .clk  (clk),
        .addr (glyph_addr),
        .we   (glyph_we),
        .data (glyph_data),
        .q    (glyph_q)
    );

    tile_render i_render (
        .clk           (clk),
        .rst           (rst),
        .raster        (raster),
        .map_q         (map_q),
        .glyph_q       (glyph_q),
        .map_rd        (map_rd),
        .map_rd_addr   (map_rd_addr),
        .glyph_rd      (glyph_rd),
        .glyph_rd_addr (glyph_rd_addr),
        .video         (video)
    );

endmodule

// ==== design/tile_pkg.sv ====
// tile map display layer, shared definitions
// screen geometry, memory address widths and the structs that
// travel between host port, raster timing, memories and renderer

package tile_pkg;

    // counter widths of the raster generator
    localparam int HCNT_W = 7;
    localparam int VCNT_W = 6;

    // cycles per line and lines per frame
    localparam logic [HCNT_W-1:0] H_TOTAL = 7'd80;
    localparam logic [VCNT_W-1:0] V_TOTAL = 6'd40;

    // visible area
    localparam logic [HCNT_W-1:0] H_ACTIVE = 7'd64;
    localparam logic [VCNT_W-1:0] V_ACTIVE = 6'd32;

    // first visible pixel leaves the renderer here
    localparam logic [HCNT_W-1:0] H_START = 7'd8;

    // sync windows run from these counts to the end of line / frame
    localparam logic [HCNT_W-1:0] HS_START = 7'd72;
    localparam logic [VCNT_W-1:0] VS_START = 6'd36;

    // 8x4 tile map, 16 glyph codes of 8 rows each
    localparam int MAP_AW   = 5;
    localparam int GLYPH_AW = 7;

    // host address, top bit picks glyph (1) or map (0) memory
    localparam int HOST_AW = 8;

    typedef struct packed {
        logic [3:0] code;
        logic [2:0] pal;
        logic       hflip;
    } map_entry_t;

    // bit 7 is the leftmost pixel of an unflipped tile
    typedef logic [7:0] glyph_row_t;

    typedef struct packed {
        logic [HOST_AW-1:0] addr;
        logic [7:0]         data;
    } host_wr_t;

    typedef struct packed {
        logic [HCNT_W-1:0] hcnt;
        logic [VCNT_W-1:0] vcnt;
        logic              hs;
        logic              vs;
        logic              de;
    } raster_t;

    typedef struct packed {
        logic       hs;
        logic       vs;
        logic       de;
        logic [3:0] color;
    } vid_out_t;

endpackage

// ==== design/tile_ram.sv ====
// generic single-port synchronous memory
// the payload type is a parameter so the same block holds
// tile map entries or glyph rows
// q is registered from addr on every clock, data is written on we

`timescale 1ns/1ps

module tile_ram #(
    // stored word, any packed type
    parameter type payload_t = logic [7:0],
    // address width, depth is 2**aw
    parameter int  aw        = 5
) (
    input  logic          clk,
    input  logic [aw-1:0] addr,
    input  logic          we,
    input  payload_t      data,
    output payload_t      q
);

    // storage array, contents come from the host at run time
    payload_t mem [0:(2**aw)-1];

    // read port
    // unconditional, so q follows addr with one cycle of latency
    // a write to the same address returns the old word on that cycle
    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

    // write port
    // the strobe already carries the enable
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
    end

endmodule

// ==== design/tile_render.sv ====
// tile renderer
// fetches one map entry and one glyph row per 8-pixel tile, stages
// the row with its attributes and shifts it out as 4-bit colour
// indices, mirrored when hflip is set
// schedule per tile t, as raster.hcnt seen on the clock edge
//   8t map read, 8t+1 map entry, 8t+2 glyph read, 8t+3 staged
//   8t+8+k pixel k leaves together with de

`timescale 1ns/1ps

module tile_render import tile_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  raster_t             raster,
    // memory read data, one cycle after the address
    input  map_entry_t          map_q,
    input  glyph_row_t          glyph_q,
    // read requests
    output logic                map_rd,
    output logic [MAP_AW-1:0]   map_rd_addr,
    output logic                glyph_rd,
    output logic [GLYPH_AW-1:0] glyph_rd_addr,
    // pixel stream
    output vid_out_t            video
);

    // one tile ready to be drawn
    typedef struct packed {
        logic [2:0] pal;
        logic       hflip;
        glyph_row_t row;
    } tile_slot_t;

    logic       active_line;
    logic       fetch_slot;
    logic       load;
    // glyph data is on glyph_q the cycle after glyph_rd
    logic       glyph_vld;
    // attributes caught while the map entry is on map_q
    logic [2:0] fetch_pal;
    logic       fetch_hflip;
    // staging register and shifter, two tiles in flight
    tile_slot_t stg;
    tile_slot_t sh;
    tile_slot_t src;

    // first pixel of a row in the current direction
    function automatic logic lead_bit(glyph_row_t row, logic flip);
        return flip ? row[0] : row[7];
    endfunction

    // drop the pixel just drawn
    function automatic glyph_row_t shift_row(glyph_row_t row, logic flip);
        return flip ? (row >> 1) : (row << 1);
    endfunction

    assign active_line = (raster.vcnt < V_ACTIVE);
    // eight fetch slots at the start of each visible line
    assign fetch_slot  = active_line && (raster.hcnt < H_ACTIVE) &&
                         (raster.hcnt[2:0] == 3'd0);
    // tile boundary, shifter takes the staged row
    assign load        = (raster.hcnt[2:0] == 3'd0);

    // read strobes and the data-valid pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            map_rd    <= 1'b0;
            glyph_rd  <= 1'b0;
            glyph_vld <= 1'b0;
        end else begin
            map_rd    <= fetch_slot;
            glyph_rd  <= map_rd;
            glyph_vld <= glyph_rd;
        end
    end

    // map address is {tile row, tile column}
    always_ff @(posedge clk) begin
        if (fetch_slot) begin
            map_rd_addr <= {raster.vcnt[4:3], raster.hcnt[5:3]};
        end
    end

    // glyph address straight from the map entry, row within the tile
    assign glyph_rd_addr = {map_q.code, raster.vcnt[2:0]};

    // hold pal and hflip, map_q may show a host write address next cycle
    always_ff @(posedge clk) begin
        if (glyph_rd) begin
            fetch_pal   <= map_q.pal;
            fetch_hflip <= map_q.hflip;
        end
    end

    // staging register
    always_ff @(posedge clk) begin
        if (glyph_vld) begin
            stg.pal   <= fetch_pal;
            stg.hflip <= fetch_hflip;
            stg.row   <= glyph_q;
        end
    end

    // pixel source, fresh tile on a boundary, else the shifter
    assign src = load ? stg : sh;

    // shifter runs every cycle, outside de its bits are not shown
    always_ff @(posedge clk) begin
        sh.pal   <= src.pal;
        sh.hflip <= src.hflip;
        sh.row   <= shift_row(src.row, src.hflip);
    end

    // output stage
    // sync and de are delayed one cycle to sit with the pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            video <= '0;
        end else begin
            video.hs    <= raster.hs;
            video.vs    <= raster.vs;
            video.de    <= raster.de;
            video.color <= raster.de ? {src.pal, lead_bit(src.row, src.hflip)} : 4'd0;
        end
    end

endmodule

// ==== design/vid_timing.sv ====
// raster generator for a 64x32 screen
// wrapping horizontal and vertical counters plus registered sync
// and display enable, all taken from the next count so every field
// of the raster struct describes the same position

`timescale 1ns/1ps

module vid_timing import tile_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output raster_t raster
);

    // next raster position
    logic [HCNT_W-1:0] h_next;
    logic [VCNT_W-1:0] v_next;
    logic              h_last;
    logic              v_last;

    assign h_last = (raster.hcnt == H_TOTAL - 1'b1);
    assign v_last = (raster.vcnt == V_TOTAL - 1'b1);

    always_comb begin
        h_next = raster.hcnt + 1'b1;
        v_next = raster.vcnt;
        // end of line, wrap and step the line counter
        if (h_last) begin
            h_next = '0;
            v_next = v_last ? '0 : raster.vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            raster <= '0;
        end else begin
            raster.hcnt <= h_next;
            raster.vcnt <= v_next;
            // sync runs to the end of line or frame
            raster.hs   <= (h_next >= HS_START);
            raster.vs   <= (v_next >= VS_START);
            // de already sits where the pixels leave the renderer
            raster.de   <= (h_next >= H_START) &&
                           (h_next < H_START + H_ACTIVE) &&
                           (v_next < V_ACTIVE);
        end
    end

endmodule

// ==== sim/tile_layer_checker.sv ====
// protocol and timing assertions for the tile layer
// bound once into the host write port and once into the renderer

`timescale 1ns/1ps

module tile_layer_checker (
    input logic clk,
    input logic rst,
    input logic map_hit,
    input logic glyph_hit,
    input logic de,
    input logic vs,
    input logic map_rd,
    input logic glyph_rd
);

    // a second strobe right behind the first could overwrite a pending write
    a_map_gap: assert property (@(posedge clk) disable iff (rst) map_hit |=> !map_hit)
        else $error("host writes to map memory on consecutive cycles");

    a_glyph_gap: assert property (@(posedge clk) disable iff (rst) glyph_hit |=> !glyph_hit)
        else $error("host writes to glyph memory on consecutive cycles");

    // no visible pixels inside vertical sync
    a_de_vs: assert property (@(posedge clk) disable iff (rst) !(de && vs))
        else $error("display enable high during vertical sync");

    // renderer reads the two memories on separate cycles
    a_rd_excl: assert property (@(posedge clk) disable iff (rst) !(map_rd && glyph_rd))
        else $error("map and glyph reads on the same cycle");

endmodule

bind host_write_port tile_layer_checker i_wr_chk (
    .clk       (clk),
    .rst       (rst),
    .map_hit   (map_hit),
    .glyph_hit (glyph_hit),
    .de        (1'b0),
    .vs        (1'b0),
    .map_rd    (map_rd),
    .glyph_rd  (glyph_rd)
);

bind tile_render tile_layer_checker i_rd_chk (
    .clk       (clk),
    .rst       (rst),
    .map_hit   (1'b0),
    .glyph_hit (1'b0),
    .de        (video.de),
    .vs        (video.vs),
    .map_rd    (map_rd),
    .glyph_rd  (glyph_rd)
);

// ==== sim/tile_layer_monitor.sv ====
// tile layer monitor
// mirrors host writes into its own map and glyph arrays, predicts
// every visible pixel and checks the raster geometry

`timescale 1ns/1ps

module tile_layer_monitor import tile_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  host_wr_t host_wr,
    input  logic     host_we,
    input  vid_out_t video,
    // cycles since the last visible line of a frame, -1 outside blank
    output int       blank_cnt,
    output int       pix_errors,
    output int       geom_errors,
    output int       frames_checked,
    output int       frames_skipped
);

    // writes later than this in blank may race the first fetch
    localparam int CLEAN_LIMIT = 600;
    localparam int LOCATIONS   = 160;

    logic [7:0] map_m   [0:31];
    logic [7:0] glyph_m [0:127];
    logic       map_seen   [0:31];
    logic       glyph_seen [0:127];
    int         written;
    int         cyc;
    int         x;
    int         y;
    int         de_run;
    int         lines;
    int         last_hs;
    int         last_vs;
    logic       prev_de;
    logic       prev_hs;
    logic       prev_vs;
    logic       prev_rst;
    logic       frame_valid;
    logic       dirty_cur;
    logic       dirty_next;
    logic       frame_end;

    // {pal, glyph bit}, map is 8 tiles wide, glyph rows 8 per code
    function automatic logic [3:0] expect_color(int px, int py);
        logic [7:0] entry;
        logic [7:0] row;
        int         col;
        entry = map_m[(py / 8) * 8 + px / 8];
        row   = glyph_m[int'(entry[7:4]) * 8 + py % 8];
        // bit 7 leftmost, mirrored when hflip is set
        col   = entry[0] ? px % 8 : 7 - px % 8;
        return {entry[3:1], row[col]};
    endfunction

    initial begin
        for (int i = 0; i < 32; i++) map_seen[i] = 1'b0;
        for (int i = 0; i < 128; i++) glyph_seen[i] = 1'b0;
        written        = 0;
        blank_cnt      = -1;
        pix_errors     = 0;
        geom_errors    = 0;
        frames_checked = 0;
        frames_skipped = 0;
        prev_rst       = 1'b1;
    end

    always @(posedge clk) begin
        if (rst) begin
            blank_cnt   <= -1;
            cyc         = 0;
            x           = 0;
            y           = 0;
            de_run      = 0;
            lines       = 0;
            last_hs     = -1;
            last_vs     = -1;
            prev_de     = 1'b0;
            prev_hs     = 1'b0;
            prev_vs     = 1'b0;
            frame_valid = 1'b0;
            dirty_cur   = 1'b0;
            dirty_next  = 1'b0;
            prev_rst    = 1'b1;
        end else begin
            cyc++;
            frame_end = 1'b0;
            if (prev_rst && video !== '0) begin
                geom_errors++;
                $display("Mismatch video after reset exp=%h got=%h", 7'h00, video);
            end
            // mirror the write, address bit 7 picks glyph memory
            if (host_we) begin
                if (host_wr.addr[7]) begin
                    glyph_m[host_wr.addr[6:0]] = host_wr.data;
                    if (!glyph_seen[host_wr.addr[6:0]]) written++;
                    glyph_seen[host_wr.addr[6:0]] = 1'b1;
                end else begin
                    map_m[host_wr.addr[4:0]] = host_wr.data;
                    if (!map_seen[host_wr.addr[4:0]]) written++;
                    map_seen[host_wr.addr[4:0]] = 1'b1;
                end
                if (!(blank_cnt >= 0 && blank_cnt < CLEAN_LIMIT)) begin
                    if (blank_cnt >= 0) dirty_next = 1'b1;
                    else dirty_cur = 1'b1;
                end
            end
            if (!video.de && video.color !== 4'h0) begin
                geom_errors++;
                $display("Mismatch color outside de exp=%h got=%h", 4'h0, video.color);
            end
            if (video.de) begin
                // first pixel of a frame
                if (!prev_de && y == 0) begin
                    dirty_cur   = dirty_next;
                    dirty_next  = 1'b0;
                    frame_valid = (written == LOCATIONS);
                end
                if (frame_valid && !dirty_cur && video.color !== expect_color(x, y)) begin
                    pix_errors++;
                    $display("Mismatch color x=%0d y=%0d exp=%h got=%h",
                             x, y, expect_color(x, y), video.color);
                end
                x++;
                de_run++;
            end
            // line end
            if (prev_de && !video.de) begin
                if (de_run != 64) begin
                    geom_errors++;
                    $display("Mismatch de_run exp=%h got=%h", 64, de_run);
                end
                de_run = 0;
                x      = 0;
                y++;
                lines++;
                if (y == 32) begin
                    if (frame_valid && !dirty_cur) frames_checked++;
                    else frames_skipped++;
                    y         = 0;
                    frame_end = 1'b1;
                end
            end
            if (video.hs && !prev_hs) begin
                if (last_hs >= 0 && cyc - last_hs != 80) begin
                    geom_errors++;
                    $display("Mismatch hs_period exp=%h got=%h", 80, cyc - last_hs);
                end
                last_hs = cyc;
            end
            if (video.vs && !prev_vs) begin
                if (last_vs >= 0 && cyc - last_vs != 3200) begin
                    geom_errors++;
                    $display("Mismatch vs_period exp=%h got=%h", 3200, cyc - last_vs);
                end
                if (last_vs >= 0 && lines != 32) begin
                    geom_errors++;
                    $display("Mismatch de_lines exp=%h got=%h", 32, lines);
                end
                lines   = 0;
                last_vs = cyc;
            end
            if (video.de) blank_cnt <= -1;
            else if (frame_end) blank_cnt <= 0;
            else if (blank_cnt >= 0) blank_cnt <= blank_cnt + 1;
            prev_de  = video.de;
            prev_hs  = video.hs;
            prev_vs  = video.vs;
            prev_rst = 1'b0;
        end
    end

endmodule

// ==== sim/tile_layer_tb.sv ====
// tile layer testbench
// clock and reset, seeded random host writes in vertical blank and
// during active display, and a cycle limit on the run

`timescale 1ns/1ps

module tile_layer_tb import tile_pkg::*; ();

    localparam int RUN_CYCLES = 8 * 3200;
    localparam int TIMEOUT    = 30000;
    // last blank cycle at which a new write is started
    localparam int BLANK_LAST = 560;

    logic     clk;
    logic     rst;
    host_wr_t host_wr;
    logic     host_we;
    vid_out_t video;
    int       seed;
    int       cycle;
    int       other_errors;
    int       blank_cnt;
    int       pix_errors;
    int       geom_errors;
    int       frames_checked;
    int       frames_skipped;

    tile_layer_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .host_wr (host_wr),
        .host_we (host_we),
        .video   (video)
    );

    tile_layer_monitor i_mon (
        .clk            (clk),
        .rst            (rst),
        .host_wr        (host_wr),
        .host_we        (host_we),
        .video          (video),
        .blank_cnt      (blank_cnt),
        .pix_errors     (pix_errors),
        .geom_errors    (geom_errors),
        .frames_checked (frames_checked),
        .frames_skipped (frames_skipped)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // one strobe, then a random gap so strobes are 2 to 4 cycles apart
    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        int gap;
        gap = 1 + ($random(seed) & 32'h7) % 3;
        @(posedge clk);
        host_wr <= '{addr: addr, data: data};
        host_we <= 1'b1;
        @(posedge clk);
        host_we <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    // hold off until vertical blank has room for another write
    task automatic blank_write(input logic [7:0] addr, input logic [7:0] data);
        while (!(blank_cnt >= 0 && blank_cnt < BLANK_LAST)) @(posedge clk);
        host_write(addr, data);
    endtask

    initial begin
        seed         = 32'h32cb;
        cycle        = 0;
        other_errors = 0;
        rst          = 1'b1;
        host_wr      = '0;
        host_we      = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // fill map and glyph memory, random hflip mix comes with the data
        for (int a = 0; a < 32; a++) blank_write(8'(a), 8'($random(seed)));
        for (int g = 0; g < 128; g++) blank_write(8'h80 | 8'(g), 8'($random(seed)));

        // random writes while a frame is being drawn
        while (blank_cnt < 0) @(posedge clk);
        while (blank_cnt >= 0) @(posedge clk);
        for (int i = 0; i < 30; i++) host_write(8'($random(seed)), 8'($random(seed)));

        // last of several writes to one map and one glyph address wins
        for (int i = 0; i < 6; i++) begin
            blank_write(8'h0d, 8'($random(seed)));
            blank_write(8'h9a, 8'($random(seed)));
        end

        while (cycle < RUN_CYCLES) @(posedge clk);
        if (frames_checked < 3) begin
            other_errors++;
            $display("only %0d frames could be compared", frames_checked);
        end
        $display("errors: pixel %0d geometry %0d other %0d, frames checked %0d skipped %0d",
                 pix_errors, geom_errors, other_errors, frames_checked, frames_skipped);
        if (pix_errors + geom_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/tile_pkg.sv
design/tile_ram.sv
design/host_write_port.sv
design/vid_timing.sv
design/tile_render.sv
design/tile_layer_top.sv
sim/tile_layer_checker.sv
sim/tile_layer_monitor.sv
sim/tile_layer_tb.sv
